// ==== design/iopmp_settings.svh ====
// IOPMP checker settings

`ifndef IOPMP_SETTINGS_SVH
`define IOPMP_SETTINGS_SVH

// Transaction and entry address width
`define IOPMP_ADDR_W 32

// Entry table depth
`define IOPMP_NUM_ENTRIES 16

// Memory domains
`define IOPMP_NUM_MDS 4

// Source IDs below this count are valid
`define IOPMP_NUM_MASTERS 4

// Wide enough to carry IDs above the master count
`define IOPMP_SID_W 3

`endif

// ==== design/iopmp_pkg.sv ====
// IOPMP checker types

`include "iopmp_settings.svh"

package iopmp_pkg;

    typedef logic [`IOPMP_ADDR_W-1:0]               addr_t;
    typedef logic [$clog2(`IOPMP_NUM_ENTRIES)-1:0]  entry_idx_t;
    typedef logic [$clog2(`IOPMP_NUM_MDS)-1:0]      md_idx_t;
    typedef logic [`IOPMP_NUM_MDS-1:0]              md_mask_t;
    typedef logic [`IOPMP_SID_W-1:0]                sid_t;

    typedef enum logic [1:0] {
        ACCESS_NONE  = 2'd0,
        ACCESS_READ  = 2'd1,
        ACCESS_WRITE = 2'd2,
        ACCESS_EXEC  = 2'd3
    } access_e;

    typedef enum logic [2:0] {
        ERR_NONE         = 3'd0,
        ERR_READ_DENIED  = 3'd1,
        ERR_WRITE_DENIED = 3'd2,
        ERR_EXEC_DENIED  = 3'd3,
        ERR_NO_MATCH     = 3'd5,
        ERR_BAD_SID      = 3'd6
    } err_code_e;

    typedef enum logic [1:0] {
        MODE_OFF   = 2'd0,
        MODE_TOR   = 2'd1,
        MODE_NA4   = 2'd2,
        MODE_NAPOT = 2'd3
    } addr_mode_e;

    typedef struct packed {
        logic [2:0] spare;
        addr_mode_e mode;
        logic       x;
        logic       w;
        logic       r;
    } entry_cfg_t;

    // Address holds the byte address shifted right by two
    typedef struct packed {
        addr_t      addr;
        entry_cfg_t cfg;
    } entry_t;

    typedef struct packed {
        addr_t   addr;
        addr_t   len;
        access_e access;
        sid_t    sid;
    } req_t;

    // Exclusive top entry index of each domain
    typedef logic [`IOPMP_NUM_MDS-1:0][$clog2(`IOPMP_NUM_ENTRIES):0] mdcfg_t;

    typedef md_mask_t [`IOPMP_NUM_MASTERS-1:0] srcmd_t;

    typedef struct packed {
        logic       detected;
        err_code_e  code;
        access_e    ttype;
        sid_t       sid;
        entry_idx_t eid;
        addr_t      addr;
    } err_record_t;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        WALK,
        TOR_FETCH,
        ALLOW,
        DENY
    } fsm_state_e;

endpackage

// ==== design/iopmp_entry_table.sv ====
// IOPMP entry table

`timescale 1ns/10ps
`include "iopmp_settings.svh"

module iopmp_entry_table (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  we_i,
    input  iopmp_pkg::entry_idx_t waddr_i,
    input  iopmp_pkg::entry_t     wdata_i,
    input  iopmp_pkg::entry_idx_t raddr_i,
    output iopmp_pkg::entry_t     rdata_o
);

    iopmp_pkg::entry_t mem_q [`IOPMP_NUM_ENTRIES];

    // All entries come up OFF so nothing matches before configuration
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `IOPMP_NUM_ENTRIES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // One cycle read for the walk
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

// ==== design/iopmp_entry_analyzer.sv ====
// IOPMP entry match

`timescale 1ns/10ps
`include "iopmp_settings.svh"

module iopmp_entry_analyzer (
    input  iopmp_pkg::addr_t   start_i,
    input  iopmp_pkg::addr_t   final_i,
    input  iopmp_pkg::access_e access_i,
    input  iopmp_pkg::entry_t  entry_i,
    input  iopmp_pkg::addr_t   prev_word_i,
    output logic               match_o,
    output logic               partial_o,
    output logic               allow_o,
    output iopmp_pkg::addr_t   entry_end_o
);

    // One extra bit so a region may end at the top of the address space
    logic [`IOPMP_ADDR_W:0] lo;
    logic [`IOPMP_ADDR_W:0] hi;
    iopmp_pkg::addr_t       word_mask;
    iopmp_pkg::addr_t       byte_mask;
    iopmp_pkg::addr_t       napot_base;
    logic                   active;
    logic                   start_in;
    logic                   final_in;

    // Trailing ones of the word address plus the zero above them
    assign word_mask  = entry_i.addr ^ (entry_i.addr + 1'b1);
    assign byte_mask  = {word_mask[`IOPMP_ADDR_W-3:0], 2'b11};
    assign napot_base = {entry_i.addr[`IOPMP_ADDR_W-3:0], 2'b00} & ~byte_mask;

    always_comb begin
        active = 1'b0;
        lo     = '0;
        hi     = '0;
        case (entry_i.cfg.mode)
            iopmp_pkg::MODE_TOR: begin
                active = 1'b1;
                lo     = {1'b0, prev_word_i[`IOPMP_ADDR_W-3:0], 2'b00};
                hi     = {1'b0, entry_i.addr[`IOPMP_ADDR_W-3:0], 2'b00};
            end
            iopmp_pkg::MODE_NAPOT: begin
                active = 1'b1;
                lo     = {1'b0, napot_base};
                hi     = {1'b0, napot_base} + {1'b0, byte_mask} + 1'b1;
            end
            // OFF and NA4 never match
            default: begin
                active = 1'b0;
            end
        endcase
    end

    assign start_in = active && ({1'b0, start_i} >= lo) && ({1'b0, start_i} < hi);
    assign final_in = active && ({1'b0, final_i} >= lo) && ({1'b0, final_i} < hi);

    assign match_o     = start_in && final_in;
    assign partial_o   = start_in && !final_in;
    assign entry_end_o = hi[`IOPMP_ADDR_W-1:0];

    always_comb begin
        case (access_i)
            iopmp_pkg::ACCESS_READ:  allow_o = entry_i.cfg.r;
            iopmp_pkg::ACCESS_WRITE: allow_o = entry_i.cfg.w;
            iopmp_pkg::ACCESS_EXEC:  allow_o = entry_i.cfg.x;
            default:                 allow_o = 1'b0;
        endcase
    end

endmodule

// ==== design/iopmp_md_tracker.sv ====
// IOPMP memory domain tracker

`timescale 1ns/10ps
`include "iopmp_settings.svh"

module iopmp_md_tracker (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  iopmp_pkg::md_mask_t enables_i,
    input  logic                start_i,
    input  logic                restore_i,
    input  logic                advance_i,
    output logic                has_md_o,
    output iopmp_pkg::md_idx_t  cur_md_o,
    output iopmp_pkg::md_idx_t  first_md_o,
    output iopmp_pkg::md_idx_t  next_md_o,
    output logic                last_md_o
);

    iopmp_pkg::md_idx_t lowest;
    iopmp_pkg::md_idx_t cur_q;
    iopmp_pkg::md_idx_t first_q;
    logic               has_md_q;

    always_comb begin
        lowest = '0;
        for (int i = `IOPMP_NUM_MDS - 1; i >= 0; i--) begin
            if (enables_i[i]) begin
                lowest = iopmp_pkg::md_idx_t'(i);
            end
        end
    end

    // Nearest enabled domain above the current one
    always_comb begin
        next_md_o = cur_q;
        last_md_o = 1'b1;
        for (int i = `IOPMP_NUM_MDS - 1; i >= 0; i--) begin
            if (enables_i[i] && (i > int'(cur_q))) begin
                next_md_o = iopmp_pkg::md_idx_t'(i);
                last_md_o = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            has_md_q <= 1'b0;
            cur_q    <= '0;
            first_q  <= '0;
        end else if (start_i) begin
            has_md_q <= |enables_i;
            cur_q    <= lowest;
            first_q  <= lowest;
        end else if (restore_i) begin
            cur_q <= first_q;
        end else if (advance_i) begin
            cur_q <= next_md_o;
        end
    end

    assign has_md_o   = has_md_q;
    assign cur_md_o   = cur_q;
    assign first_md_o = first_q;

endmodule

// ==== design/iopmp_match_fsm.sv ====
// IOPMP entry walk

`timescale 1ns/10ps
`include "iopmp_settings.svh"

module iopmp_match_fsm (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  iopmp_en_i,
    input  iopmp_pkg::mdcfg_t     mdcfg_i,
    input  iopmp_pkg::srcmd_t     srcmd_i,
    input  logic                  req_valid_i,
    input  iopmp_pkg::req_t       req_i,
    output logic                  ready_o,
    output logic                  resp_valid_o,
    output logic                  resp_allow_o,
    output iopmp_pkg::entry_idx_t entry_raddr_o,
    input  iopmp_pkg::entry_t     entry_i,
    output logic                  err_strobe_o,
    output iopmp_pkg::err_code_e  err_code_o,
    output iopmp_pkg::access_e    err_access_o,
    output iopmp_pkg::sid_t       err_sid_o,
    output iopmp_pkg::entry_idx_t err_entry_o,
    output iopmp_pkg::addr_t      err_addr_o
);

    iopmp_pkg::fsm_state_e state_q, state_d;
    iopmp_pkg::addr_t      start_q, start_d;
    iopmp_pkg::entry_idx_t cur_entry_q, cur_entry_d;
    iopmp_pkg::addr_t      prev_word_q, prev_word_d;
    logic                  prev_valid_q, prev_valid_d;
    iopmp_pkg::err_code_e  code_q, code_d;
    iopmp_pkg::err_code_e  deny_code;
    iopmp_pkg::addr_t      final_q;
    iopmp_pkg::access_e    access_q;
    iopmp_pkg::sid_t       sid_q;
    iopmp_pkg::sid_t       sid_sel;
    iopmp_pkg::md_mask_t   enables;
    logic                  accept;

    // Domain bounds in entry indices, one bit wider than an index
    logic [$clog2(`IOPMP_NUM_ENTRIES):0] first_base;
    logic [$clog2(`IOPMP_NUM_ENTRIES):0] first_top;
    logic [$clog2(`IOPMP_NUM_ENTRIES):0] cur_top;
    logic [$clog2(`IOPMP_NUM_ENTRIES):0] next_base;

    logic               md_restore, md_advance, has_md, last_md;
    iopmp_pkg::md_idx_t cur_md, first_md, next_md;
    logic               hit, partial, allow;
    iopmp_pkg::addr_t   entry_end;

    assign accept  = (state_q == iopmp_pkg::IDLE) && req_valid_i;
    assign ready_o = (state_q == iopmp_pkg::IDLE);

    // Domains are looked up with the incoming sid while idle
    assign sid_sel = (state_q == iopmp_pkg::IDLE) ? req_i.sid : sid_q;
    assign enables = (sid_sel < `IOPMP_NUM_MASTERS) ?
                     srcmd_i[sid_sel[$clog2(`IOPMP_NUM_MASTERS)-1:0]] : '0;

    assign first_base = (first_md == '0) ? '0 : mdcfg_i[first_md - 1'b1];
    assign first_top  = mdcfg_i[first_md];
    assign cur_top    = mdcfg_i[cur_md];
    assign next_base  = mdcfg_i[next_md - 1'b1];

    always_comb begin
        case (access_q)
            iopmp_pkg::ACCESS_READ:  deny_code = iopmp_pkg::ERR_READ_DENIED;
            iopmp_pkg::ACCESS_WRITE: deny_code = iopmp_pkg::ERR_WRITE_DENIED;
            iopmp_pkg::ACCESS_EXEC:  deny_code = iopmp_pkg::ERR_EXEC_DENIED;
            default:                 deny_code = iopmp_pkg::ERR_NO_MATCH;
        endcase
    end

    always_comb begin
        state_d      = state_q;
        start_d      = start_q;
        cur_entry_d  = cur_entry_q;
        prev_word_d  = prev_word_q;
        prev_valid_d = prev_valid_q;
        code_d       = code_q;
        md_restore   = 1'b0;
        md_advance   = 1'b0;
        resp_valid_o = 1'b0;
        resp_allow_o = 1'b0;
        err_strobe_o = 1'b0;

        case (state_q)
            iopmp_pkg::IDLE: begin
                start_d = req_i.addr;
                if (req_valid_i) begin
                    code_d  = iopmp_pkg::ERR_NONE;
                    state_d = iopmp_pkg::SETUP;
                    if (!iopmp_en_i) begin
                        state_d = iopmp_pkg::DENY;
                    end else if (req_i.sid >= `IOPMP_NUM_MASTERS) begin
                        state_d = iopmp_pkg::DENY;
                        code_d  = iopmp_pkg::ERR_BAD_SID;
                    end
                end
            end
            iopmp_pkg::SETUP: begin
                md_restore   = 1'b1;
                cur_entry_d  = first_base[$clog2(`IOPMP_NUM_ENTRIES)-1:0];
                prev_word_d  = '0;
                prev_valid_d = (first_base == '0);
                if (has_md && (first_top > first_base)) begin
                    state_d = iopmp_pkg::WALK;
                end else begin
                    // No domain or an empty first domain
                    state_d = iopmp_pkg::DENY;
                    code_d  = iopmp_pkg::ERR_NO_MATCH;
                end
            end
            iopmp_pkg::WALK: begin
                if (entry_i.cfg.mode == iopmp_pkg::MODE_TOR && !prev_valid_q) begin
                    // TOR base comes from the entry below
                    cur_entry_d = cur_entry_q - 1'b1;
                    state_d     = iopmp_pkg::TOR_FETCH;
                end else if (hit || partial) begin
                    if (!allow) begin
                        state_d = iopmp_pkg::DENY;
                        code_d  = deny_code;
                    end else if (hit) begin
                        state_d = iopmp_pkg::ALLOW;
                    end else begin
                        // Head is covered, check the rest from the first domain
                        start_d = entry_end;
                        state_d = iopmp_pkg::SETUP;
                    end
                end else if ({1'b0, cur_entry_q} + 1'b1 >= cur_top) begin
                    if (last_md) begin
                        state_d = iopmp_pkg::DENY;
                        code_d  = iopmp_pkg::ERR_NO_MATCH;
                    end else begin
                        cur_entry_d  = next_base[$clog2(`IOPMP_NUM_ENTRIES)-1:0];
                        md_advance   = 1'b1;
                        prev_word_d  = '0;
                        prev_valid_d = (next_base == '0);
                    end
                end else if (cur_entry_q == `IOPMP_NUM_ENTRIES - 1) begin
                    state_d = iopmp_pkg::DENY;
                    code_d  = iopmp_pkg::ERR_NO_MATCH;
                end else begin
                    cur_entry_d  = cur_entry_q + 1'b1;
                    prev_word_d  = entry_i.addr;
                    prev_valid_d = 1'b1;
                end
            end
            iopmp_pkg::TOR_FETCH: begin
                prev_word_d  = entry_i.addr;
                prev_valid_d = 1'b1;
                cur_entry_d  = cur_entry_q + 1'b1;
                state_d      = iopmp_pkg::WALK;
            end
            iopmp_pkg::ALLOW: begin
                resp_valid_o = 1'b1;
                resp_allow_o = 1'b1;
                state_d      = iopmp_pkg::IDLE;
            end
            iopmp_pkg::DENY: begin
                resp_valid_o = 1'b1;
                err_strobe_o = (code_q != iopmp_pkg::ERR_NONE);
                state_d      = iopmp_pkg::IDLE;
            end
            default: begin
                state_d = iopmp_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= iopmp_pkg::IDLE;
            start_q      <= '0;
            cur_entry_q  <= '0;
            prev_word_q  <= '0;
            prev_valid_q <= 1'b0;
            code_q       <= iopmp_pkg::ERR_NONE;
        end else begin
            state_q      <= state_d;
            start_q      <= start_d;
            cur_entry_q  <= cur_entry_d;
            prev_word_q  <= prev_word_d;
            prev_valid_q <= prev_valid_d;
            code_q       <= code_d;
        end
    end

    // Held for the whole check
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            final_q  <= '0;
            access_q <= iopmp_pkg::ACCESS_NONE;
            sid_q    <= '0;
        end else if (accept) begin
            final_q  <= req_i.addr + req_i.len - 1'b1;
            access_q <= req_i.access;
            sid_q    <= req_i.sid;
        end
    end

    assign entry_raddr_o = cur_entry_d;
    assign err_code_o    = code_q;
    assign err_access_o  = access_q;
    assign err_sid_o     = sid_q;
    assign err_entry_o   = cur_entry_q;
    assign err_addr_o    = start_q;

    iopmp_md_tracker u_md_tracker (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .enables_i  (enables),
        .start_i    (accept),
        .restore_i  (md_restore),
        .advance_i  (md_advance),
        .has_md_o   (has_md),
        .cur_md_o   (cur_md),
        .first_md_o (first_md),
        .next_md_o  (next_md),
        .last_md_o  (last_md)
    );

    iopmp_entry_analyzer u_analyzer (
        .start_i     (start_q),
        .final_i     (final_q),
        .access_i    (access_q),
        .entry_i     (entry_i),
        .prev_word_i (prev_word_q),
        .match_o     (hit),
        .partial_o   (partial),
        .allow_o     (allow),
        .entry_end_o (entry_end)
    );

endmodule

// ==== design/iopmp_error_capture.sv ====
// IOPMP error record

`timescale 1ns/10ps

module iopmp_error_capture (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   strobe_i,
    input  iopmp_pkg::err_code_e   code_i,
    input  iopmp_pkg::access_e     access_i,
    input  iopmp_pkg::sid_t        sid_i,
    input  iopmp_pkg::entry_idx_t  entry_i,
    input  iopmp_pkg::addr_t       addr_i,
    output iopmp_pkg::err_record_t err_o
);

    iopmp_pkg::access_e ttype;

    // Type 0 is reserved, so a typeless access reports as a read
    always_comb begin
        case (access_i)
            iopmp_pkg::ACCESS_NONE: ttype = iopmp_pkg::ACCESS_READ;
            default:                ttype = access_i;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_o <= '0;
        end else if (strobe_i) begin
            err_o.detected <= 1'b1;
            err_o.code     <= code_i;
            err_o.ttype    <= ttype;
            err_o.sid      <= sid_i;
            err_o.eid      <= entry_i;
            err_o.addr     <= addr_i;
        end else begin
            err_o <= '0;
        end
    end

endmodule

// ==== design/iopmp_checker.sv ====
// IOPMP transaction checker

`timescale 1ns/10ps

module iopmp_checker (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   iopmp_en_i,
    input  iopmp_pkg::mdcfg_t      mdcfg_i,
    input  iopmp_pkg::srcmd_t      srcmd_i,
    input  logic                   entry_we_i,
    input  iopmp_pkg::entry_idx_t  entry_waddr_i,
    input  iopmp_pkg::entry_t      entry_wdata_i,
    input  logic                   req_valid_i,
    input  iopmp_pkg::req_t        req_i,
    output logic                   ready_o,
    output logic                   resp_valid_o,
    output logic                   resp_allow_o,
    output iopmp_pkg::err_record_t err_o
);

    iopmp_pkg::entry_idx_t entry_raddr;
    iopmp_pkg::entry_t     entry_rdata;
    logic                  err_strobe;
    iopmp_pkg::err_code_e  err_code;
    iopmp_pkg::access_e    err_access;
    iopmp_pkg::sid_t       err_sid;
    iopmp_pkg::entry_idx_t err_entry;
    iopmp_pkg::addr_t      err_addr;

    iopmp_entry_table u_entry_table (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .we_i    (entry_we_i),
        .waddr_i (entry_waddr_i),
        .wdata_i (entry_wdata_i),
        .raddr_i (entry_raddr),
        .rdata_o (entry_rdata)
    );

    iopmp_match_fsm u_match_fsm (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .iopmp_en_i    (iopmp_en_i),
        .mdcfg_i       (mdcfg_i),
        .srcmd_i       (srcmd_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .ready_o       (ready_o),
        .resp_valid_o  (resp_valid_o),
        .resp_allow_o  (resp_allow_o),
        .entry_raddr_o (entry_raddr),
        .entry_i       (entry_rdata),
        .err_strobe_o  (err_strobe),
        .err_code_o    (err_code),
        .err_access_o  (err_access),
        .err_sid_o     (err_sid),
        .err_entry_o   (err_entry),
        .err_addr_o    (err_addr)
    );

    iopmp_error_capture u_error_capture (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .strobe_i (err_strobe),
        .code_i   (err_code),
        .access_i (err_access),
        .sid_i    (err_sid),
        .entry_i  (err_entry),
        .addr_i   (err_addr),
        .err_o    (err_o)
    );

endmodule

// ==== tests/iopmp_sva.sv ====
// IOPMP checker assertions

`timescale 1ns/10ps

module iopmp_sva (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   ready_o,
    input logic                   resp_valid_o,
    input logic                   resp_allow_o,
    input iopmp_pkg::err_record_t err_o
);

    int fail_count = 0;

    // Idle with quiet outputs as soon as reset lifts
    ready_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> ready_o && !resp_valid_o && (err_o == '0))
        else begin
            $error("ready low or outputs busy right after reset");
            fail_count++;
        end

    resp_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_valid_o |=> !resp_valid_o)
        else begin
            $error("response pulse lasted two cycles");
            fail_count++;
        end

    // Record only follows a denial
    err_after_deny: assert property (@(posedge clk_i) disable iff (!rst_ni)
        err_o.detected |-> $past(resp_valid_o && !resp_allow_o))
        else begin
            $error("error record without a denial the cycle before");
            fail_count++;
        end

endmodule

bind iopmp_checker iopmp_sva u_sva (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ready_o      (ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_allow_o (resp_allow_o),
    .err_o        (err_o)
);

// ==== tests/iopmp_tb.sv ====
// IOPMP checker testbench

`timescale 1ns/10ps

module iopmp_tb;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_REQUESTS = 26;
    localparam int CYCLE_LIMIT  = 40 * NUM_REQUESTS + RESET_CYCLES;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   iopmp_en_i;
    iopmp_pkg::mdcfg_t      mdcfg_i;
    iopmp_pkg::srcmd_t      srcmd_i;
    logic                   entry_we_i;
    iopmp_pkg::entry_idx_t  entry_waddr_i;
    iopmp_pkg::entry_t      entry_wdata_i;
    logic                   req_valid_i;
    iopmp_pkg::req_t        req_i;
    logic                   ready_o;
    logic                   resp_valid_o;
    logic                   resp_allow_o;
    iopmp_pkg::err_record_t err_o;

    logic [31:0]            rng_state;
    logic                   got_allow;
    iopmp_pkg::err_record_t got_err;
    int                     cycles;
    int                     errors;
    int                     test_errors;
    int                     tests_run;
    int                     tests_failed;

    iopmp_checker dut_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .iopmp_en_i    (iopmp_en_i),
        .mdcfg_i       (mdcfg_i),
        .srcmd_i       (srcmd_i),
        .entry_we_i    (entry_we_i),
        .entry_waddr_i (entry_waddr_i),
        .entry_wdata_i (entry_wdata_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .ready_o       (ready_o),
        .resp_valid_o  (resp_valid_o),
        .resp_allow_o  (resp_allow_o),
        .err_o         (err_o)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #20 clk_i = ~clk_i;

    // Run limit sized from the request count
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles without finishing", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word address of a power-of-two region, PMP style
    function automatic logic [31:0] napot_word(input logic [31:0] base, input logic [31:0] size);
        return (base >> 2) | ((size >> 3) - 32'd1);
    endfunction

    task automatic write_entry(input int idx, input logic [31:0] word,
                               input iopmp_pkg::addr_mode_e mode, input logic [2:0] xwr);
        @(posedge clk_i);
        #2;
        entry_we_i               = 1'b1;
        entry_waddr_i            = iopmp_pkg::entry_idx_t'(idx);
        entry_wdata_i.addr       = word;
        entry_wdata_i.cfg.spare  = 3'b000;
        entry_wdata_i.cfg.mode   = mode;
        entry_wdata_i.cfg.x      = xwr[2];
        entry_wdata_i.cfg.w      = xwr[1];
        entry_wdata_i.cfg.r      = xwr[0];
        @(posedge clk_i);
        #2;
        entry_we_i = 1'b0;
    endtask

    // One request, then the response and the record a cycle later
    task automatic run_request(input logic [2:0] sid, input iopmp_pkg::access_e acc,
                               input logic [31:0] addr, input logic [31:0] len);
        while (!ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #2;
        req_i.addr   = addr;
        req_i.len    = len;
        req_i.access = acc;
        req_i.sid    = sid;
        req_valid_i  = 1'b1;
        @(posedge clk_i);
        #2;
        req_valid_i = 1'b0;
        @(negedge clk_i);
        while (!resp_valid_o) begin
            @(negedge clk_i);
        end
        got_allow = resp_allow_o;
        @(negedge clk_i);
        got_err = err_o;
    endtask

    task automatic check_allow(input string what);
        assert (got_allow === 1'b1) else begin
            $display("Error: time %0t: %s was denied", $time, what);
            test_errors++;
        end
        assert (got_err === '0) else begin
            $display("Error: time %0t: %s left an error record", $time, what);
            test_errors++;
        end
    endtask

    task automatic check_denial(input string what, input iopmp_pkg::err_code_e code,
                                input iopmp_pkg::access_e ttype, input logic [2:0] sid,
                                input logic check_eid, input logic [3:0] eid,
                                input logic [31:0] addr);
        assert (got_allow === 1'b0) else begin
            $display("Error: time %0t: %s was allowed", $time, what);
            test_errors++;
        end
        if (code == iopmp_pkg::ERR_NONE) begin
            assert (got_err === '0) else begin
                $display("Error: time %0t: %s gave a record %h", $time, what, got_err);
                test_errors++;
            end
        end else begin
            assert (got_err.detected === 1'b1 && got_err.code === code &&
                    got_err.ttype === ttype && got_err.sid === sid &&
                    got_err.addr === addr) else begin
                $display("Error: time %0t: %s record %h, code %0d expected", $time, what,
                         got_err, code);
                test_errors++;
            end
            assert (!check_eid || got_err.eid === eid) else begin
                $display("Error: time %0t: %s entry %0d, %0d expected", $time, what,
                         got_err.eid, eid);
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
        end
        errors      = errors + test_errors;
        test_errors = 0;
    endtask

    initial begin
        logic [31:0]        len;
        logic [31:0]        addr;
        iopmp_pkg::access_e acc;
        int                 sva_fails;
        rst_ni        = 1'b0;
        iopmp_en_i    = 1'b0;
        mdcfg_i       = '0;
        srcmd_i       = '0;
        entry_we_i    = 1'b0;
        entry_waddr_i = '0;
        entry_wdata_i = '0;
        req_valid_i   = 1'b0;
        req_i         = '0;
        rng_state     = 32'd39;
        cycles        = 0;
        errors        = 0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // Two entries per domain, tops are exclusive
        mdcfg_i[0] = 5'd2;
        mdcfg_i[1] = 5'd4;
        mdcfg_i[2] = 5'd6;
        mdcfg_i[3] = 5'd8;
        srcmd_i[0] = 4'b0001;
        srcmd_i[1] = 4'b1000;
        srcmd_i[2] = 4'b0110;
        srcmd_i[3] = 4'b0000;
        write_entry(0, 32'h1000 >> 2, iopmp_pkg::MODE_OFF, 3'b000);
        write_entry(1, 32'h2000 >> 2, iopmp_pkg::MODE_TOR, 3'b011);
        write_entry(2, 32'h4000 >> 2, iopmp_pkg::MODE_OFF, 3'b000);
        write_entry(3, 32'h4100 >> 2, iopmp_pkg::MODE_TOR, 3'b001);
        write_entry(4, 32'h4200 >> 2, iopmp_pkg::MODE_TOR, 3'b001);
        write_entry(6, napot_word(32'h8000, 32'h100), iopmp_pkg::MODE_NAPOT, 3'b001);

        run_request(3'd0, iopmp_pkg::ACCESS_READ, 32'h1800, 32'd4);
        check_denial("disabled read", iopmp_pkg::ERR_NONE, iopmp_pkg::ACCESS_READ,
                     3'd0, 1'b0, 4'd0, 32'h0);
        finish_test("disabled checker");
        @(posedge clk_i);
        #2;
        iopmp_en_i = 1'b1;

        for (int i = 0; i < 20; i++) begin
            rng_state = xorshift(rng_state);
            len       = 32'd1 + (rng_state & 32'h3F);
            acc       = rng_state[20] ? iopmp_pkg::ACCESS_WRITE : iopmp_pkg::ACCESS_READ;
            rng_state = xorshift(rng_state);
            addr      = 32'h1000 + (rng_state % (32'h1000 - len + 32'd1));
            run_request(3'd0, acc, addr, len);
            check_allow("random TOR access");
        end
        finish_test("TOR read write");

        run_request(3'd1, iopmp_pkg::ACCESS_WRITE, 32'h8040, 32'd16);
        check_denial("NAPOT write", iopmp_pkg::ERR_WRITE_DENIED, iopmp_pkg::ACCESS_WRITE,
                     3'd1, 1'b1, 4'd6, 32'h8040);
        run_request(3'd1, iopmp_pkg::ACCESS_READ, 32'h80F0, 32'd16);
        check_allow("NAPOT read");
        finish_test("NAPOT read only");

        run_request(3'd2, iopmp_pkg::ACCESS_READ, 32'h40F0, 32'h20);
        check_allow("split read");
        finish_test("partial match");

        run_request(3'd5, iopmp_pkg::ACCESS_READ, 32'h1100, 32'd4);
        check_denial("sid 5 read", iopmp_pkg::ERR_BAD_SID, iopmp_pkg::ACCESS_READ,
                     3'd5, 1'b0, 4'd0, 32'h1100);
        run_request(3'd0, iopmp_pkg::ACCESS_READ, 32'h9000, 32'd8);
        check_denial("uncovered read", iopmp_pkg::ERR_NO_MATCH, iopmp_pkg::ACCESS_READ,
                     3'd0, 1'b1, 4'd1, 32'h9000);
        finish_test("error codes");

        sva_fails = dut_i.u_sva.fail_count;
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/iopmp_pkg.sv
design/iopmp_entry_table.sv
design/iopmp_entry_analyzer.sv
design/iopmp_md_tracker.sv
design/iopmp_match_fsm.sv
design/iopmp_error_capture.sv
design/iopmp_checker.sv
tests/iopmp_sva.sv
tests/iopmp_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := iopmp_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
